/* bchChienCorrect.sv */
`default_nettype none
`timescale 1ns/1ps

module bchChienCorrect (
	input logic clk,
	input logic reset,
	input bchPkg::bchLocator locator,
	input logic locValid,
	input logic [bchPkg::codeLength-1:0] rxWord,
	output bchPkg::bchResult result,
	output logic resultValid
);

	import bchPkg::*;

	logic [fieldBits-1:0] term1;
	logic [fieldBits-1:0] term2;
	logic [fieldBits-1:0] term3;
	logic [codeLength-1:0] word;
	logic [msgLength-1:0] rawMsg;
	logic [msgLength-1:0] fixMsg;
	logic [countBits-1:0] degree;
	logic [countBits-1:0] rootCount;
	logic [countBits-1:0] finalRoots;
	codeIndex bitIndex;
	logic running;
	logic isRoot;
	logic matched;
	logic lastStep;

	// sigma(x) = 1 + t1 + t2 + t3, zero when the sum of terms is one
	assign isRoot = (term1 ^ term2 ^ term3) == fieldBits'(1);
	assign finalRoots = rootCount + countBits'(isRoot);
	assign matched = finalRoots == degree;
	assign lastStep = bitIndex == codeIndex'(codeLength - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			bitIndex <= '0;
			resultValid <= 1'b0;
		end else begin
			resultValid <= 1'b0;
			if (locValid) begin
				running <= 1'b1;
				bitIndex <= '0;
			end else if (running) begin
				bitIndex <= bitIndex + 1'b1;
				if (lastStep) begin
					running <= 1'b0;
					resultValid <= 1'b1;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// position 14 first, evaluated at alpha^-14 = alpha
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (locValid) begin
			term1 <= gfMul(locator.sigma1, gfExp(1));
			term2 <= gfMul(locator.sigma2, gfExp(2));
			term3 <= gfMul(locator.sigma3, gfExp(3));
			degree <= locator.degree;
			word <= rxWord;
			rawMsg <= rxWord[codeLength-1 -: msgLength];
			rootCount <= '0;
		end else if (running) begin
			term1 <= gfMul(term1, gfExp(1));
			term2 <= gfMul(term2, gfExp(2));
			term3 <= gfMul(term3, gfExp(3));
			word <= {word[codeLength-2:0], 1'b0};
			rootCount <= finalRoots;
			if (bitIndex < codeIndex'(msgLength))
				fixMsg <= {fixMsg[msgLength-2:0], word[codeLength-1] ^ isRoot};
			if (lastStep) begin
				result.message <= matched ? fixMsg : rawMsg;
				result.numCorrected <= matched ? finalRoots : '0;
				result.failed <= !matched;
			end
		end
	end

endmodule

`default_nettype wire

/* bchEncoder.sv */
`default_nettype none
`timescale 1ns/1ps

module bchEncoder (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [bchPkg::msgLength-1:0] message,
	output logic codeBit,
	output logic codeValid
);

	import bchPkg::*;

	logic [msgLength-1:0] msgShift;
	logic [parityLength-1:0] parity;
	codeIndex bitIndex;
	logic running;
	logic inMessage;
	logic feedback;

	assign inMessage = bitIndex < codeIndex'(msgLength);
	assign feedback = msgShift[msgLength-1] ^ parity[parityLength-1];
	assign codeBit = inMessage ? msgShift[msgLength-1] : parity[parityLength-1];
	assign codeValid = running;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			bitIndex <= '0;
		end else if (start) begin
			running <= 1'b1;
			bitIndex <= '0;
		end else if (running) begin
			bitIndex <= bitIndex + 1'b1;
			if (bitIndex == codeIndex'(codeLength - 1))
				running <= 1'b0;
		end
	end

	// message bits go out and into the divider, then the remainder follows
	always_ff @(posedge clk) begin
		if (start) begin
			msgShift <= message;
			parity <= '0;
		end else if (running) begin
			if (inMessage) begin
				msgShift <= {msgShift[msgLength-2:0], 1'b0};
				parity <= {parity[parityLength-2:0], 1'b0}
					^ (feedback ? genPoly[parityLength-1:0] : '0);
			end else begin
				parity <= {parity[parityLength-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

/* bchErrorLocator.sv */
`default_nettype none
`timescale 1ns/1ps

module bchErrorLocator (
	input logic clk,
	input logic reset,
	input bchPkg::bchSyndromes syndromes,
	input logic synValid,
	output bchPkg::bchLocator locator,
	output logic locValid
);

	import bchPkg::*;

	locState state;
	bchSyndromes synReg;
	bchLocator solved;
	logic [fieldBits-1:0] s2;
	logic [fieldBits-1:0] det;
	logic [fieldBits-1:0] num;
	logic [fieldBits-1:0] quot;
	logic [fieldBits-1:0] sig3;

	// binary code: S2 = S1^2
	assign s2 = gfMul(synReg.s1, synReg.s1);

	// closed-form Peterson for t = 3
	assign quot = gfMul(num, gfInv(det));
	assign sig3 = det ^ gfMul(synReg.s1, quot);

	always_comb begin
		solved = '0;
		if (det != '0) begin
			solved.sigma1 = synReg.s1;
			solved.sigma2 = quot;
			solved.sigma3 = sig3;
			solved.degree = (sig3 != '0) ? countBits'(3) : countBits'(2);
		end else if (synReg.s1 != '0) begin
			solved.sigma1 = synReg.s1;
			solved.degree = countBits'(1);
		end else if (synReg.s3 != '0 || synReg.s5 != '0) begin
			// full degree with no roots makes the Chien stage report failure
			solved.degree = countBits'(correctCap);
		end
	end

	assign locValid = state == done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (synValid) state <= calcDet;
				calcDet: state <= calcCoef;
				calcCoef: state <= done;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			idle: if (synValid) synReg <= syndromes;
			calcDet: begin
				// det = S1^3 + S3, num = S1^2 S3 + S5
				det <= gfMul(synReg.s1, s2) ^ synReg.s3;
				num <= gfMul(s2, synReg.s3) ^ synReg.s5;
			end
			calcCoef: locator <= solved;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* bchLoopRegs.sv */
`default_nettype none
`timescale 1ns/1ps

module bchLoopRegs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bchPkg::addrBits-1:0] paddr,
	input logic [bchPkg::dataBits-1:0] pwdata,
	output logic [bchPkg::dataBits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output bchPkg::bchJob job,
	output logic start,
	input bchPkg::bchResult result,
	input logic resultValid
);

	import bchPkg::*;

	bchResult lastResult;
	logic [dataBits-1:0] wordCount;
	logic [dataBits-1:0] bitCount;
	logic access;
	logic addrHit;
	logic writable;
	logic writeEn;
	logic busy;
	logic doneFlag;
	logic wrCtrl;
	logic wrMessage;
	logic wrErrPattern;

	assign access = psel & penable;
	assign writeEn = access & pwrite & addrHit & writable;
	assign wrCtrl = writeEn && paddr == regCtrl;
	assign wrMessage = writeEn && paddr == regMessage;
	assign wrErrPattern = writeEn && paddr == regErrPattern;

	// no wait states
	assign pready = 1'b1;
	assign pslverr = access & (!addrHit | (pwrite & !writable));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode and read mux
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		prdata = '0;
		addrHit = 1'b1;
		writable = 1'b0;
		case (paddr)
			regCtrl: writable = 1'b1;
			regMessage: begin
				prdata = dataBits'(job.message);
				writable = 1'b1;
			end
			regErrPattern: begin
				prdata = dataBits'(job.errPattern);
				writable = 1'b1;
			end
			regStatus: prdata = dataBits'({lastResult.numCorrected, 1'b0,
				lastResult.failed, doneFlag, busy});
			regResult: prdata = dataBits'(lastResult.message);
			regWordCount: prdata = wordCount;
			regBitCount: prdata = bitCount;
			default: addrHit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			job <= '0;
			start <= 1'b0;
			busy <= 1'b0;
			doneFlag <= 1'b0;
			lastResult <= '0;
			wordCount <= '0;
			bitCount <= '0;
		end else begin
			start <= 1'b0;
			if (wrMessage)
				job.message <= pwdata[msgLength-1:0];
			if (wrErrPattern)
				job.errPattern <= pwdata[codeLength-1:0];
			// a start while a job runs is dropped
			if (wrCtrl && pwdata[0] && !busy) begin
				start <= 1'b1;
				busy <= 1'b1;
				doneFlag <= 1'b0;
			end
			if (resultValid) begin
				busy <= 1'b0;
				doneFlag <= 1'b1;
				lastResult <= result;
				wordCount <= wordCount + 1'b1;
				bitCount <= bitCount + dataBits'(result.numCorrected);
			end
			if (wrCtrl && pwdata[1]) begin
				wordCount <= '0;
				bitCount <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* bchLoopback.sv */
`default_nettype none
`timescale 1ns/1ps

module bchLoopback (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [bchPkg::addrBits-1:0] paddr,
	input logic [bchPkg::dataBits-1:0] pwdata,
	output logic [bchPkg::dataBits-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	import bchPkg::*;

	bchJob job;
	bchSyndromes syndromes;
	bchLocator locator;
	bchResult result;
	logic [codeLength-1:0] errShift;
	logic [codeLength-1:0] rxWord;
	logic start;
	logic codeBit;
	logic codeValid;
	logic rxBit;
	logic rxValid;
	logic synValid;
	logic locValid;
	logic resultValid;

	bchLoopRegs bchLoopRegs_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.job(job),
		.start(start),
		.result(result),
		.resultValid(resultValid)
	);

	bchEncoder bchEncoder_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.message(job.message),
		.codeBit(codeBit),
		.codeValid(codeValid)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// channel: pattern bit 14 hits the first code bit out
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (start)
			errShift <= job.errPattern;
		else if (codeValid)
			errShift <= {errShift[codeLength-2:0], 1'b0};
	end

	assign rxBit = codeBit ^ errShift[codeLength-1];
	assign rxValid = codeValid;

	bchSyndrome bchSyndrome_i (
		.clk(clk),
		.reset(reset),
		.rxBit(rxBit),
		.rxValid(rxValid),
		.syndromes(syndromes),
		.synValid(synValid),
		.rxWord(rxWord)
	);

	bchErrorLocator bchErrorLocator_i (
		.clk(clk),
		.reset(reset),
		.syndromes(syndromes),
		.synValid(synValid),
		.locator(locator),
		.locValid(locValid)
	);

	bchChienCorrect bchChienCorrect_i (
		.clk(clk),
		.reset(reset),
		.locator(locator),
		.locValid(locValid),
		.rxWord(rxWord),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

/* bchLoopbackTb.sv */
`default_nettype none
`timescale 1ns/1ps

module bchLoopbackTb;

	import bchPkg::*;

	typedef struct packed {
		logic [msgLength-1:0] message;
		logic [codeLength-1:0] pattern;
		logic randomPattern;
		logic [2:0] weight;
		logic [7:0] expStatus;
	} testRow;

	localparam int numRows = 14;
	localparam int cycleLimit = 200 * numRows + 1000;
	localparam logic [31:0] lfsrSeed = 32'h1413_3129;

	// expected status holds numCorrected in 5:4 and done in bit 1 with busy and failed clear
	localparam testRow stimTable [numRows] = '{
		'{5'h13, 15'h0000, 1'b0, 3'd0, 8'h02},
		'{5'h00, 15'h0000, 1'b0, 3'd0, 8'h02},
		'{5'h1F, 15'h4000, 1'b0, 3'd1, 8'h12},
		'{5'h0A, 15'h0001, 1'b0, 3'd1, 8'h12},
		'{5'h15, 15'h4001, 1'b0, 3'd2, 8'h22},
		'{5'h07, 15'h7000, 1'b0, 3'd3, 8'h32},
		'{5'h19, 15'h0007, 1'b0, 3'd3, 8'h32},
		'{5'h0C, 15'h0000, 1'b1, 3'd1, 8'h12},
		'{5'h11, 15'h0000, 1'b1, 3'd2, 8'h22},
		'{5'h1E, 15'h0000, 1'b1, 3'd3, 8'h32},
		'{5'h03, 15'h0000, 1'b1, 3'd2, 8'h22},
		'{5'h16, 15'h0000, 1'b1, 3'd3, 8'h32},
		'{5'h09, 15'h0000, 1'b1, 3'd1, 8'h12},
		'{5'h1B, 15'h0000, 1'b1, 3'd3, 8'h32}
	};

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addrBits-1:0] paddr;
	logic [dataBits-1:0] pwdata;
	logic [dataBits-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [31:0] lfsrState;
	int errorCount;
	int checkCount;
	int cycleCount = 0;

	tbClockGen clockGen_i (
		.clk(clk),
		.reset(reset)
	);

	bchLoopback bchLoopback_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	initial begin
		wait (cycleCount >= cycleLimit);
		$display("timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("Simulation FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// one LFSR step per bit
	task automatic drawBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic drawPattern(input int weight, output logic [codeLength-1:0] pattern);
		int pos;
		int placed;
		pattern = '0;
		placed = 0;
		while (placed < weight) begin
			drawBits(4, pos);
			if (pos < codeLength && !pattern[pos]) begin
				pattern[pos] = 1'b1;
				placed++;
			end
		end
	endtask

	task automatic apbWrite(input logic [addrBits-1:0] addr, input logic [dataBits-1:0] data,
		output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [addrBits-1:0] addr, output logic [dataBits-1:0] data,
		output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic waitDone(output logic [dataBits-1:0] status);
		logic err;
		status = '0;
		while (!status[1])
			apbRead(regStatus, status, err);
	endtask

	task automatic runJob(input logic [msgLength-1:0] message,
		input logic [codeLength-1:0] pattern, output logic [dataBits-1:0] status);
		logic err;
		apbWrite(regMessage, dataBits'(message), err);
		apbWrite(regErrPattern, dataBits'(pattern), err);
		apbWrite(regCtrl, 32'h1, err);
		waitDone(status);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : mainSequence
		logic [dataBits-1:0] status;
		logic [dataBits-1:0] data;
		logic err;
		logic [codeLength-1:0] pattern;
		int weightSum;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsrState = lfsrSeed;
		errorCount = 0;
		checkCount = 0;
		@(negedge reset);

		apbRead(regStatus, data, err);
		checkValue("status after reset", 32'h0, data);
		checkValue("pslverr after reset", 32'h0, 32'(err));
		checkValue("pready", 32'h1, 32'(pready));
		apbRead(regWordCount, data, err);
		checkValue("wordCount after reset", 32'h0, data);
		apbRead(regBitCount, data, err);
		checkValue("bitCount after reset", 32'h0, data);

		// readback and bus errors
		apbWrite(regMessage, 32'h15, err);
		checkValue("message write pslverr", 32'h0, 32'(err));
		apbWrite(regErrPattern, 32'h4A21, err);
		apbRead(regMessage, data, err);
		checkValue("message readback", 32'h15, data);
		apbRead(regErrPattern, data, err);
		checkValue("errPattern readback", 32'h4A21, data);
		apbRead(8'h1C, data, err);
		checkValue("unmapped read pslverr", 32'h1, 32'(err));
		apbRead(8'h06, data, err);
		checkValue("misaligned read pslverr", 32'h1, 32'(err));
		apbWrite(8'h40, 32'h0, err);
		checkValue("unmapped write pslverr", 32'h1, 32'(err));
		apbWrite(regStatus, 32'h3, err);
		checkValue("status write pslverr", 32'h1, 32'(err));
		apbWrite(regResult, 32'h1F, err);
		checkValue("result write pslverr", 32'h1, 32'(err));
		apbWrite(regWordCount, 32'h5, err);
		checkValue("wordCount write pslverr", 32'h1, 32'(err));
		apbWrite(regBitCount, 32'h5, err);
		checkValue("bitCount write pslverr", 32'h1, 32'(err));

		apbWrite(regCtrl, 32'h2, err);
		weightSum = 0;
		for (int row = 0; row < numRows; row++) begin
			if (stimTable[row].randomPattern)
				drawPattern(int'(stimTable[row].weight), pattern);
			else
				pattern = stimTable[row].pattern;
			runJob(stimTable[row].message, pattern, status);
			checkValue($sformatf("row %0d status", row), 32'(stimTable[row].expStatus), status);
			apbRead(regResult, data, err);
			checkValue($sformatf("row %0d message", row), 32'(stimTable[row].message), data);
			weightSum += int'(stimTable[row].weight);
		end

		apbRead(regWordCount, data, err);
		checkValue("wordCount after table", 32'(numRows), data);
		apbRead(regBitCount, data, err);
		checkValue("bitCount after table", 32'(weightSum), data);
		apbWrite(regCtrl, 32'h2, err);
		apbRead(regWordCount, data, err);
		checkValue("wordCount after clear", 32'h0, data);
		apbRead(regBitCount, data, err);
		checkValue("bitCount after clear", 32'h0, data);

		// second start lands while the first job runs
		apbWrite(regMessage, 32'h0B, err);
		apbWrite(regErrPattern, 32'h0410, err);
		apbWrite(regCtrl, 32'h1, err);
		apbRead(regStatus, data, err);
		checkValue("busy after start", 32'h1, 32'(data[0]));
		apbWrite(regMessage, 32'h14, err);
		apbWrite(regCtrl, 32'h1, err);
		waitDone(status);
		checkValue("busy start status", 32'h22, status);
		apbRead(regResult, data, err);
		checkValue("busy start message", 32'h0B, data);
		apbRead(regWordCount, data, err);
		checkValue("busy start wordCount", 32'h1, data);
		apbRead(regBitCount, data, err);
		checkValue("busy start bitCount", 32'h2, data);

		// a weight-four pattern is past the correction capability
		drawPattern(4, pattern);
		runJob(5'h0E, pattern, status);
		checkValue("weight four busy", 32'h0, 32'(status[0]));
		apbRead(regWordCount, data, err);
		checkValue("weight four wordCount", 32'h2, data);

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bchPkg.sv */
`default_nettype none

package bchPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// code size and field
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int codeLength = 15;
	localparam int msgLength = 5;
	localparam int parityLength = 10;
	localparam int correctCap = 3;
	localparam int fieldBits = 4;
	localparam int countBits = $clog2(correctCap + 1);

	// x^4 + x + 1, terms below x^4
	localparam logic [fieldBits-1:0] fieldPoly = 4'b0011;
	// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
	localparam logic [parityLength:0] genPoly = 11'b101_0011_0111;

	localparam int addrBits = 8;
	localparam int dataBits = 32;

	typedef logic [$clog2(codeLength)-1:0] codeIndex;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(16) arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [fieldBits-1:0] gfMul(
		input logic [fieldBits-1:0] a,
		input logic [fieldBits-1:0] b
	);
		logic [fieldBits-1:0] acc;
		logic [fieldBits-1:0] shifted;
		acc = '0;
		shifted = a;
		for (int i = 0; i < fieldBits; i++) begin
			if (b[i])
				acc = acc ^ shifted;
			shifted = {shifted[fieldBits-2:0], 1'b0} ^ (shifted[fieldBits-1] ? fieldPoly : '0);
		end
		return acc;
	endfunction

	// alpha^power for power 0..15
	function automatic logic [fieldBits-1:0] gfExp(input int unsigned power);
		logic [fieldBits-1:0] value;
		value = fieldBits'(1);
		for (int i = 0; i < codeLength; i++) begin
			if (i < power)
				value = gfMul(value, fieldBits'(2));
		end
		return value;
	endfunction

	function automatic logic [fieldBits-1:0] gfLog(input logic [fieldBits-1:0] value);
		logic [fieldBits-1:0] power;
		power = '0;
		for (int i = 0; i < codeLength; i++) begin
			if (gfExp(i) == value)
				power = fieldBits'(i);
		end
		return power;
	endfunction

	// zero maps to zero
	function automatic logic [fieldBits-1:0] gfInv(input logic [fieldBits-1:0] value);
		return (value == '0) ? '0 : gfExp(codeLength - int'(gfLog(value)));
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath structs and enums
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [msgLength-1:0] message;
		logic [codeLength-1:0] errPattern;
	} bchJob;

	typedef struct packed {
		logic [fieldBits-1:0] s1;
		logic [fieldBits-1:0] s3;
		logic [fieldBits-1:0] s5;
	} bchSyndromes;

	typedef struct packed {
		logic [fieldBits-1:0] sigma1;
		logic [fieldBits-1:0] sigma2;
		logic [fieldBits-1:0] sigma3;
		logic [countBits-1:0] degree;
	} bchLocator;

	typedef struct packed {
		logic [msgLength-1:0] message;
		logic [countBits-1:0] numCorrected;
		logic failed;
	} bchResult;

	typedef enum logic [1:0] {
		idle,
		calcDet,
		calcCoef,
		done
	} locState;

	typedef enum logic [addrBits-1:0] {
		regCtrl = 8'h00,
		regMessage = 8'h04,
		regErrPattern = 8'h08,
		regStatus = 8'h0C,
		regResult = 8'h10,
		regWordCount = 8'h14,
		regBitCount = 8'h18
	} regAddr;

endpackage

`default_nettype wire

/* bchSyndrome.sv */
`default_nettype none
`timescale 1ns/1ps

module bchSyndrome (
	input logic clk,
	input logic reset,
	input logic rxBit,
	input logic rxValid,
	output bchPkg::bchSyndromes syndromes,
	output logic synValid,
	output logic [bchPkg::codeLength-1:0] rxWord
);

	import bchPkg::*;

	logic [fieldBits-1:0] acc1;
	logic [fieldBits-1:0] acc3;
	logic [fieldBits-1:0] acc5;
	logic [fieldBits-1:0] next1;
	logic [fieldBits-1:0] next3;
	logic [fieldBits-1:0] next5;
	logic [fieldBits-1:0] bitTerm;
	codeIndex bitIndex;
	logic firstBit;

	assign firstBit = bitIndex == '0;
	assign bitTerm = {{(fieldBits - 1){1'b0}}, rxBit};

	// Horner step; a new word starts from zero
	assign next1 = (firstBit ? '0 : gfMul(acc1, gfExp(1))) ^ bitTerm;
	assign next3 = (firstBit ? '0 : gfMul(acc3, gfExp(3))) ^ bitTerm;
	assign next5 = (firstBit ? '0 : gfMul(acc5, gfExp(5))) ^ bitTerm;

	assign syndromes = '{s1: acc1, s3: acc3, s5: acc5};

	always_ff @(posedge clk) begin
		if (reset) begin
			bitIndex <= '0;
			synValid <= 1'b0;
		end else begin
			synValid <= 1'b0;
			if (rxValid) begin
				if (bitIndex == codeIndex'(codeLength - 1)) begin
					bitIndex <= '0;
					synValid <= 1'b1;
				end else begin
					bitIndex <= bitIndex + 1'b1;
				end
			end
		end
	end

	// accumulators and word buffer
	// the word lands with its first bit at the top, bit i = coefficient of x^i
	always_ff @(posedge clk) begin
		if (rxValid) begin
			acc1 <= next1;
			acc3 <= next3;
			acc5 <= next5;
			rxWord <= {rxWord[codeLength-2:0], rxBit};
		end
	end

endmodule

`default_nettype wire

/* project.f */
bchPkg.sv
bchEncoder.sv
bchSyndrome.sv
bchErrorLocator.sv
bchChienCorrect.sv
bchLoopRegs.sv
bchLoopback.sv
tbClockGen.sv
bchLoopbackTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module bchLoopbackTb -f project.f -o simv
output=$(./obj_dir/simv)
echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi

/* tbClockGen.sv */
`default_nettype none
`timescale 1ns/1ps

module tbClockGen (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for four rising edges, released just after the fourth
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire
